// ==== compile.f ====
+incdir+src
src/noc_types_pkg.sv
src/tile_bus_pkg.sv
src/serial_link_tx.sv
src/serial_link_rx.sv
src/packet_router.sv
src/tile_bus_regs.sv
src/tile.sv
src/tile_wrapper.sv
verif/tile_wrapper_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f compile.f --top-module tile_wrapper_tb -o tile_wrapper_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/tile_wrapper_sim)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx 'All tests passed!'; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1

// ==== verif/tile_wrapper_tb.sv ====
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module tile_wrapper_tb
    import noc_types_pkg::*;
    import tile_bus_pkg::*;
();
    localparam int CLK_NS        = 4;
    localparam int HOP_CYCLES    = 50 * `CLKS_PER_BIT;
    localparam int PKTS_PER_TILE = 10;
    // about 40 random packets of up to two hops, with four times that as margin.
    localparam int TRAFFIC_NS    = 4 * PKTS_PER_TILE * 2 * HOP_CYCLES * CLK_NS;
    localparam int WATCHDOG_NS   = 4 * TRAFFIC_NS;

    typedef struct packed {
        node_id_t src;
        word_t    payload;
    } rx_entry_t;

    logic      clk;
    logic      rst_n;
    bus_req_t  bus_req [`NUM_TILES];
    bus_rsp_t  bus_rsp [`NUM_TILES];
    rx_entry_t exp_q [`NUM_TILES][$];
    int        in_flight [`NUM_TILES];
    word_t     tx_model [`NUM_TILES];
    int        want [`NUM_TILES];
    node_id_t  dst [`NUM_TILES][PKTS_PER_TILE];
    word_t     pay [`NUM_TILES][PKTS_PER_TILE];
    integer    seed;
    int        fail_count;
    int        tests_run;
    int        tests_failed;

    tile_wrapper uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    // walks the grid x first, then y; returns the tile where the packet is delivered.
    function automatic int expected_route(input int src, input int dest,
                                          output int hops, output int via);
        int cur;
        cur  = src;
        hops = 0;
        via  = -1;
        while (cur != dest) begin
            if (((cur ^ dest) & 1) != 0) begin
                cur = cur ^ 1;
            end else begin
                cur = cur ^ 2;
            end
            hops++;
            if (cur != dest) begin
                via = cur;
            end
        end
        return cur;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] %0d ns %s expected 0x%08h actual 0x%08h",
                 $time, name, expected, actual);
        fail_count++;
    endtask

    // drive on the falling edge and sample one ns before the rising edge.
    task automatic bus_access(input int t, input logic write, input addr_t addr,
                              input word_t wdata, input strobe_t strobe,
                              output word_t rdata, output logic err, output logic stalled);
        @(negedge clk);
        bus_req[t].wen    = write;
        bus_req[t].ren    = !write;
        bus_req[t].addr   = addr;
        bus_req[t].wdata  = wdata;
        bus_req[t].strobe = strobe;
        stalled = 1'b0;
        #1;
        while (bus_rsp[t].request_stall) begin
            stalled = 1'b1;
            @(negedge clk);
            #1;
        end
        rdata = bus_rsp[t].rdata;
        err   = bus_rsp[t].error;
        @(negedge clk);
        bus_req[t] = '0;
    endtask

    task automatic bus_write(input int t, input addr_t addr, input word_t wdata,
                             input strobe_t strobe, output logic err, output logic stalled);
        word_t rdata;
        bus_access(t, 1'b1, addr, wdata, strobe, rdata, err, stalled);
    endtask

    task automatic bus_read(input int t, input addr_t addr, output word_t rdata,
                            output logic err);
        logic stalled;
        bus_access(t, 1'b0, addr, '0, '0, rdata, err, stalled);
    endtask

    task automatic load_payload(input int t, input word_t data, input strobe_t strobe);
        logic err;
        logic stalled;
        bus_write(t, `REG_TX_DATA, data, strobe, err, stalled);
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                tx_model[t][8*b +: 8] = data[8*b +: 8];
            end
        end
        if (err !== 1'b0) begin
            report_mismatch($sformatf("tile%0d tx_data error", t), 0, 32'(err));
        end
    endtask

    task automatic send_packet(input int t, input int dest, output logic stalled);
        logic      err;
        int        hops;
        int        via;
        int        final_tile;
        rx_entry_t e;
        bus_write(t, `REG_TX_CTRL, word_t'(dest), 4'hF, err, stalled);
        if (err !== 1'b0) begin
            report_mismatch($sformatf("tile%0d tx_ctrl error", t), 0, 32'(err));
        end
        final_tile = expected_route(t, dest, hops, via);
        e.src      = node_id_t'(t);
        e.payload  = tx_model[t];
        exp_q[final_tile].push_back(e);
        in_flight[t]++;
    endtask

    task automatic wait_count(input int t, input int n);
        word_t st;
        logic  err;
        bus_read(t, `REG_STATUS, st, err);
        while (int'(st[6:4]) < n) begin
            bus_read(t, `REG_STATUS, st, err);
        end
    endtask

    task automatic check_status(input int t, input int count, input logic overrun);
        word_t st;
        logic  err;
        bus_read(t, `REG_STATUS, st, err);
        if (int'(st[6:4]) != count) begin
            report_mismatch($sformatf("tile%0d status count", t), 32'(count), 32'(st[6:4]));
        end
        if (st[9] !== overrun) begin
            report_mismatch($sformatf("tile%0d status overrun", t), 32'(overrun), 32'(st[9]));
        end
    endtask

    // matches by source, so packets of one source must arrive in send order.
    task automatic pop_and_check(input int t);
        word_t st;
        word_t data;
        logic  err;
        int    idx;
        bus_read(t, `REG_STATUS, st, err);
        bus_read(t, `REG_RX_DATA, data, err);
        if (err !== 1'b0) begin
            report_mismatch($sformatf("tile%0d rx_data error", t), 0, 32'(err));
        end
        idx = -1;
        for (int i = 0; i < exp_q[t].size(); i++) begin
            if (idx < 0 && exp_q[t][i].src == st[1:0]) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("%0d ns: tile %0d received a packet from tile %0d that was never sent",
                     $time, t, st[1:0]);
            fail_count++;
        end else begin
            if (data !== exp_q[t][idx].payload) begin
                report_mismatch($sformatf("tile%0d rx_data from tile%0d", t, st[1:0]),
                                exp_q[t][idx].payload, data);
            end
            in_flight[st[1:0]]--;
            exp_q[t].delete(idx);
        end
    endtask

    task automatic check_error(input string name, input word_t rdata, input logic err);
        if (err !== 1'b1) begin
            report_mismatch({name, " error"}, 1, 32'(err));
        end
        if (rdata !== '0) begin
            report_mismatch({name, " rdata"}, 0, rdata);
        end
    endtask

    task automatic traffic_tile(input int t);
        int    sent;
        int    got;
        word_t st;
        logic  err;
        logic  stalled;
        sent = 0;
        got  = 0;
        while (sent < PKTS_PER_TILE || got < want[t]) begin
            if (sent < PKTS_PER_TILE && in_flight[t] == 0) begin
                load_payload(t, pay[t][sent], 4'hF);
                send_packet(t, int'(dst[t][sent]), stalled);
                sent++;
            end
            bus_read(t, `REG_STATUS, st, err);
            if (st[6:4] != 3'd0) begin
                pop_and_check(t);
                got++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int fails_before);
        tests_run++;
        if (fail_count == fails_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d failed checks", name, fail_count - fails_before);
        end
    endtask

    initial begin
        int    fb;
        int    hops;
        int    via;
        int    final_tile;
        logic  stalled;
        logic  saw_stall;
        logic  err;
        word_t rdata;
        seed         = 32'h6287_da5e;
        fail_count   = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        for (int t = 0; t < `NUM_TILES; t++) begin
            bus_req[t]   = '0;
            in_flight[t] = 0;
            tx_model[t]  = '0;
            want[t]      = 0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        fb = fail_count;
        #1;
        for (int t = 0; t < `NUM_TILES; t++) begin
            if (bus_rsp[t].request_stall !== 1'b0) begin
                report_mismatch($sformatf("tile%0d request_stall", t), 0,
                                32'(bus_rsp[t].request_stall));
            end
            bus_read(t, `REG_STATUS, rdata, err);
            if (rdata !== '0) begin
                report_mismatch($sformatf("tile%0d status", t), 0, rdata);
            end
        end
        finish_test("1 reset state", fb);

        fb = fail_count;
        load_payload(0, 32'hAABB_CCDD, 4'b0011);
        load_payload(0, 32'h1122_3344, 4'b1100);
        send_packet(0, 1, stalled);
        wait_count(1, 1);
        pop_and_check(1);
        finish_test("2 unicast 0 to 1 with byte merge", fb);

        fb = fail_count;
        load_payload(0, 32'h0300_5A01, 4'hF);
        send_packet(0, 3, stalled);
        final_tile = expected_route(0, 3, hops, via);
        wait_count(final_tile, 1);
        check_status(via, 0, 1'b0);
        pop_and_check(final_tile);
        load_payload(2, 32'h0100_A502, 4'hF);
        send_packet(2, 1, stalled);
        final_tile = expected_route(2, 1, hops, via);
        wait_count(final_tile, 1);
        check_status(via, 0, 1'b0);
        pop_and_check(final_tile);
        load_payload(2, 32'h0200_C3C3, 4'hF);
        send_packet(2, 2, stalled);
        wait_count(2, 1);
        pop_and_check(2);
        finish_test("3 two-hop and loopback", fb);

        fb = fail_count;
        bus_read(0, 32'h0000_0010, rdata, err);
        check_error("tile0 unmapped read", rdata, err);
        bus_access(1, 1'b1, 32'h0000_0040, 32'hFFFF_FFFF, 4'hF, rdata, err, stalled);
        check_error("tile1 unmapped write", rdata, err);
        bus_read(2, `REG_RX_DATA, rdata, err);
        check_error("tile2 empty rx_data read", rdata, err);
        bus_access(3, 1'b1, `REG_STATUS, 32'h0000_0300, 4'hF, rdata, err, stalled);
        check_error("tile3 status write", rdata, err);
        bus_access(0, 1'b1, `REG_RX_DATA, 32'h1234_5678, 4'hF, rdata, err, stalled);
        check_error("tile0 rx_data write", rdata, err);
        finish_test("4 bus errors", fb);

        fb = fail_count;
        for (int t = 0; t < `NUM_TILES; t++) begin
            for (int i = 0; i < PKTS_PER_TILE; i++) begin
                dst[t][i]  = node_id_t'($random(seed));
                pay[t][i]  = word_t'($random(seed));
                final_tile = expected_route(t, int'(dst[t][i]), hops, via);
                want[final_tile]++;
            end
        end
        fork
            traffic_tile(0);
            traffic_tile(1);
            traffic_tile(2);
            traffic_tile(3);
        join
        for (int t = 0; t < `NUM_TILES; t++) begin
            if (exp_q[t].size() != 0) begin
                report_mismatch($sformatf("tile%0d undelivered packets", t), 0,
                                32'(exp_q[t].size()));
            end
            check_status(t, 0, 1'b0);
        end
        finish_test("5 random concurrent traffic", fb);

        fb = fail_count;
        saw_stall = 1'b0;
        for (int i = 0; i < 6; i++) begin
            load_payload(0, 32'hB0B0_0000 + i, 4'hF);
            send_packet(0, 1, stalled);
            saw_stall = saw_stall | stalled;
        end
        if (!saw_stall) begin
            report_mismatch("tile0 request_stall seen", 1, 0);
        end
        // tile 1's FIFO fills before anything is read.
        wait_count(1, `RX_FIFO_DEPTH);
        for (int i = 0; i < 6; i++) begin
            wait_count(1, 1);
            pop_and_check(1);
        end
        check_status(1, 0, 1'b0);
        finish_test("6 back-pressure", fb);

        $display("summary: %0d tests, %0d failed, %0d failed checks",
                 tests_run, tests_failed, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== src/tile_wrapper.sv ====
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module tile_wrapper
    import noc_types_pkg::*;
    import tile_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  bus_req_t bus_req [`NUM_TILES],
    output bus_rsp_t bus_rsp [`NUM_TILES]
);
    logic link_tx [`NUM_TILES][`NUM_LINKS];
    logic link_rx [`NUM_TILES][`NUM_LINKS];

    for (genvar t = 0; t < `NUM_TILES; t++) begin : g_tile
        // the x neighbour differs in id bit 0, the y neighbour in id bit 1.
        assign link_rx[t][0] = link_tx[t ^ 1][0];
        assign link_rx[t][1] = link_tx[t ^ 2][1];

        tile u_tile (
            .clk     (clk),
            .rst_n   (rst_n),
            .my_id   (node_id_t'(t)),
            .bus_req (bus_req[t]),
            .bus_rsp (bus_rsp[t]),
            .link_rx (link_rx[t]),
            .link_tx (link_tx[t])
        );
    end

endmodule

// ==== src/tile.sv ====
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module tile
    import noc_types_pkg::*;
    import tile_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  node_id_t my_id,
    input  bus_req_t bus_req,
    output bus_rsp_t bus_rsp,
    input  logic     link_rx [`NUM_LINKS],
    output logic     link_tx [`NUM_LINKS]
);
    logic inject_valid;
    pkt_t inject_pkt;
    logic inject_take;
    logic deliver_strobe;
    pkt_t deliver_pkt;
    logic fifo_full;
    logic rx_valid [`NUM_LINKS];
    pkt_t rx_pkt [`NUM_LINKS];
    logic rx_take [`NUM_LINKS];
    logic overrun [`NUM_LINKS];
    logic tx_busy [`NUM_LINKS];
    logic tx_start [`NUM_LINKS];
    pkt_t tx_pkt [`NUM_LINKS];

    tile_bus_regs u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .bus_req        (bus_req),
        .bus_rsp        (bus_rsp),
        .my_id          (my_id),
        .inject_valid   (inject_valid),
        .inject_pkt     (inject_pkt),
        .inject_take    (inject_take),
        .deliver_strobe (deliver_strobe),
        .deliver_pkt    (deliver_pkt),
        .fifo_full      (fifo_full),
        .overrun        (overrun)
    );

    packet_router u_router (
        .clk            (clk),
        .rst_n          (rst_n),
        .my_id          (my_id),
        .inject_valid   (inject_valid),
        .inject_pkt     (inject_pkt),
        .inject_take    (inject_take),
        .rx_valid       (rx_valid),
        .rx_pkt         (rx_pkt),
        .rx_take        (rx_take),
        .tx_busy        (tx_busy),
        .tx_start       (tx_start),
        .tx_pkt         (tx_pkt),
        .fifo_full      (fifo_full),
        .deliver_strobe (deliver_strobe),
        .deliver_pkt    (deliver_pkt)
    );

    for (genvar l = 0; l < `NUM_LINKS; l++) begin : g_link
        serial_link_tx u_tx (
            .clk      (clk),
            .rst_n    (rst_n),
            .tx_start (tx_start[l]),
            .tx_pkt   (tx_pkt[l]),
            .tx_busy  (tx_busy[l]),
            .line     (link_tx[l])
        );

        serial_link_rx u_rx (
            .clk      (clk),
            .rst_n    (rst_n),
            .line     (link_rx[l]),
            .rx_valid (rx_valid[l]),
            .rx_pkt   (rx_pkt[l]),
            .rx_take  (rx_take[l]),
            .overrun  (overrun[l])
        );
    end

endmodule

// ==== src/tile_bus_regs.sv ====
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module tile_bus_regs
    import noc_types_pkg::*;
    import tile_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  bus_req_t bus_req,
    output bus_rsp_t bus_rsp,
    input  node_id_t my_id,
    output logic     inject_valid,
    output pkt_t     inject_pkt,
    input  logic     inject_take,
    input  logic     deliver_strobe,
    input  pkt_t     deliver_pkt,
    output logic     fifo_full,
    input  logic     overrun [`NUM_LINKS]
);
    localparam int PTR_W = $clog2(`RX_FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`RX_FIFO_DEPTH - 1);

    pkt_t             fifo_mem [`RX_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count_q;
    word_t            tx_data_q;
    logic             overrun_q;
    logic             fifo_empty;
    logic             pop;
    logic             ctrl_wr;
    logic             ctrl_stall;
    pkt_t             head;
    word_t            status;

    assign fifo_empty = (count_q == '0);
    assign fifo_full  = (count_q == CNT_W'(`RX_FIFO_DEPTH));
    assign head       = fifo_mem[rd_ptr];
    assign pop        = bus_req.ren && (bus_req.addr == `REG_RX_DATA) && !fifo_empty;
    assign ctrl_wr    = bus_req.wen && (bus_req.addr == `REG_TX_CTRL);
    // a new send waits until the router has taken the pending one.
    assign ctrl_stall = ctrl_wr && inject_valid && !inject_take;

    always_comb begin
        status      = '0;
        status[1:0] = fifo_empty ? 2'b00 : head.src;
        status[6:4] = 3'(count_q);
        status[8]   = inject_valid;
        status[9]   = overrun_q;
    end

    always_comb begin
        bus_rsp               = '0;
        bus_rsp.request_stall = ctrl_stall;
        if (bus_req.ren) begin
            case (bus_req.addr)
                `REG_TX_DATA: bus_rsp.rdata = tx_data_q;
                `REG_TX_CTRL: bus_rsp.rdata = inject_valid ? word_t'(inject_pkt.dest) : '0;
                `REG_RX_DATA: begin
                    if (fifo_empty) begin
                        bus_rsp.error = 1'b1;
                    end else begin
                        bus_rsp.rdata = head.payload;
                    end
                end
                `REG_STATUS: bus_rsp.rdata = status;
                default:     bus_rsp.error = 1'b1;
            endcase
        end else if (bus_req.wen) begin
            bus_rsp.error = !((bus_req.addr == `REG_TX_DATA) || ctrl_wr);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_data_q    <= '0;
            inject_valid <= 1'b0;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count_q      <= '0;
            overrun_q    <= 1'b0;
        end else begin
            if (bus_req.wen && (bus_req.addr == `REG_TX_DATA)) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus_req.strobe[b]) begin
                        tx_data_q[8*b +: 8] <= bus_req.wdata[8*b +: 8];
                    end
                end
            end
            if (ctrl_wr && !ctrl_stall) begin
                inject_valid <= 1'b1;
            end else if (inject_take) begin
                inject_valid <= 1'b0;
            end
            if (deliver_strobe) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            count_q   <= count_q + CNT_W'(deliver_strobe) - CNT_W'(pop);
            overrun_q <= overrun_q | overrun[0] | overrun[1];
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_wr && !ctrl_stall) begin
            inject_pkt.dest    <= bus_req.wdata[1:0];
            inject_pkt.src     <= my_id;
            inject_pkt.payload <= tx_data_q;
        end
        if (deliver_strobe) begin
            fifo_mem[wr_ptr] <= deliver_pkt;
        end
    end

endmodule

// ==== src/packet_router.sv ====
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module packet_router
    import noc_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  node_id_t my_id,
    input  logic     inject_valid,
    input  pkt_t     inject_pkt,
    output logic     inject_take,
    input  logic     rx_valid [`NUM_LINKS],
    input  pkt_t     rx_pkt [`NUM_LINKS],
    output logic     rx_take [`NUM_LINKS],
    input  logic     tx_busy [`NUM_LINKS],
    output logic     tx_start [`NUM_LINKS],
    output pkt_t     tx_pkt [`NUM_LINKS],
    input  logic     fifo_full,
    output logic     deliver_strobe,
    output pkt_t     deliver_pkt
);
    // source 0 is local injection and source l+1 is the receiver of link l.
    localparam int NUM_SRC = `NUM_LINKS + 1;

    pkt_t               src_pkt [NUM_SRC];
    route_t             src_route [NUM_SRC];
    logic [NUM_SRC-1:0] src_valid;
    logic [NUM_SRC-1:0] eligible;
    logic [1:0]         rr_q;
    logic [1:0]         grant_idx;
    logic               grant_any;
    pkt_t               sel_pkt;
    route_t             sel_route;

    // x first, then y.
    function automatic route_t route_of(input node_id_t dest, input node_id_t id);
        if (dest[0] != id[0]) begin
            return ROUTE_X;
        end
        if (dest[1] != id[1]) begin
            return ROUTE_Y;
        end
        return ROUTE_LOCAL;
    endfunction

    always_comb begin
        src_pkt[0]   = inject_pkt;
        src_valid[0] = inject_valid;
        for (int l = 0; l < `NUM_LINKS; l++) begin
            src_pkt[l+1]   = rx_pkt[l];
            src_valid[l+1] = rx_valid[l];
        end
        for (int s = 0; s < NUM_SRC; s++) begin
            src_route[s] = route_of(src_pkt[s].dest, my_id);
            case (src_route[s])
                ROUTE_X: eligible[s] = src_valid[s] && !tx_busy[0];
                ROUTE_Y: eligible[s] = src_valid[s] && !tx_busy[1];
                default: eligible[s] = src_valid[s] && !fifo_full;
            endcase
        end
    end

    // first eligible source at or after the round-robin pointer.
    always_comb begin
        int idx;
        grant_any = 1'b0;
        grant_idx = rr_q;
        for (int k = 0; k < NUM_SRC; k++) begin
            idx = (int'(rr_q) + k) % NUM_SRC;
            if (!grant_any && eligible[idx]) begin
                grant_any = 1'b1;
                grant_idx = 2'(idx);
            end
        end
    end

    assign sel_pkt   = src_pkt[grant_idx];
    assign sel_route = src_route[grant_idx];

    assign inject_take    = grant_any && (grant_idx == 2'd0);
    assign deliver_strobe = grant_any && (sel_route == ROUTE_LOCAL);
    assign deliver_pkt    = sel_pkt;
    assign tx_start[0]    = grant_any && (sel_route == ROUTE_X);
    assign tx_start[1]    = grant_any && (sel_route == ROUTE_Y);

    for (genvar l = 0; l < `NUM_LINKS; l++) begin : g_link
        assign rx_take[l] = grant_any && (grant_idx == 2'(l + 1));
        assign tx_pkt[l]  = sel_pkt;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_q <= '0;
        end else if (grant_any) begin
            rr_q <= (grant_idx == 2'(NUM_SRC - 1)) ? 2'd0 : grant_idx + 2'd1;
        end
    end

endmodule

// ==== src/serial_link_rx.sv ====
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module serial_link_rx
    import noc_types_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic line,
    output logic rx_valid,
    output pkt_t rx_pkt,
    input  logic rx_take,
    output logic overrun
);
    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] MID_CLK  = CNT_W'(`CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(`CLKS_PER_BIT - 1);

    typedef enum logic {
        RX_IDLE,
        RX_FRAME
    } rx_state_t;

    rx_state_t        state;
    logic [1:0]       sync_q;
    logic             line_s;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic [2:0]       byte_cnt;
    byte_t            byte_q;
    logic [31:0]      asm_q;
    logic             sample;
    logic             frame_end;
    logic             pkt_done;
    logic             hold_full;

    assign line_s    = sync_q[1];
    assign sample    = (state == RX_FRAME) && (clk_cnt == MID_CLK);
    assign frame_end = sample && (bit_cnt == 4'd9);
    assign pkt_done  = frame_end && (byte_cnt == 3'd4);
    assign hold_full = rx_valid && !rx_take;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], line};
        end
    end

    // the frame ends at the middle of the stop bit so the next start edge is not missed.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (!line_s) begin
                        state   <= RX_FRAME;
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end
                default: begin
                    clk_cnt <= (clk_cnt == LAST_CLK) ? '0 : clk_cnt + 1'b1;
                    if (clk_cnt == LAST_CLK) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    // a start bit that is high again at its middle was a glitch.
                    if (sample && (bit_cnt == 4'd0) && line_s) begin
                        state <= RX_IDLE;
                    end
                    if (frame_end) begin
                        state    <= RX_IDLE;
                        byte_cnt <= pkt_done ? 3'd0 : byte_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample && (bit_cnt != 4'd0) && (bit_cnt != 4'd9)) begin
            byte_q <= {line_s, byte_q[7:1]};
        end
        if (frame_end) begin
            asm_q <= {byte_q, asm_q[31:8]};
        end
        if (pkt_done && !hold_full) begin
            rx_pkt.dest    <= asm_q[1:0];
            rx_pkt.src     <= asm_q[3:2];
            rx_pkt.payload <= {byte_q, asm_q[31:8]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            overrun <= pkt_done && hold_full;
            if (pkt_done && !hold_full) begin
                rx_valid <= 1'b1;
            end else if (rx_take) begin
                rx_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== src/serial_link_tx.sv ====
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module serial_link_tx
    import noc_types_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic tx_start,
    input  pkt_t tx_pkt,
    output logic tx_busy,
    output logic line
);
    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(`CLKS_PER_BIT - 1);

    logic [39:0]      shift_q;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic [2:0]       byte_cnt;
    logic             load;
    logic             bit_end;
    logic             data_next;

    assign load      = tx_start && !tx_busy;
    assign bit_end   = tx_busy && (clk_cnt == LAST_CLK);
    // a data bit follows the start bit and each of the first seven data bits.
    assign data_next = bit_end && (bit_cnt < 4'd8);

    // the header byte goes out first, then the payload from its low byte up.
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= {tx_pkt.payload, 4'b0000, tx_pkt.src, tx_pkt.dest};
        end else if (data_next) begin
            shift_q <= {1'b0, shift_q[39:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_busy  <= 1'b0;
            line     <= 1'b1;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else if (load) begin
            tx_busy  <= 1'b1;
            line     <= 1'b0;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else if (tx_busy) begin
            if (!bit_end) begin
                clk_cnt <= clk_cnt + 1'b1;
            end else begin
                clk_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    bit_cnt <= '0;
                    if (byte_cnt == 3'd4) begin
                        tx_busy <= 1'b0;
                        line    <= 1'b1;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                        line     <= 1'b0;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    line    <= (bit_cnt == 4'd8) ? 1'b1 : shift_q[0];
                end
            end
        end
    end

endmodule

// ==== src/tile_bus_pkg.sv ====
package tile_bus_pkg;
    import noc_types_pkg::*;

    typedef logic [31:0] addr_t;

    typedef logic [3:0] strobe_t;

    typedef struct packed {
        logic    wen;
        logic    ren;
        addr_t   addr;
        word_t   wdata;
        strobe_t strobe;
    } bus_req_t;

    typedef struct packed {
        word_t rdata;
        logic  error;
        logic  request_stall;
    } bus_rsp_t;

endpackage

// ==== src/noc_types_pkg.sv ====
package noc_types_pkg;

    // bit 0 is the x coordinate, bit 1 the y coordinate.
    typedef logic [1:0] node_id_t;

    typedef logic [31:0] word_t;

    typedef logic [7:0] byte_t;

    // on the wire the header byte carries dest in bits 1:0 and src in bits 3:2.
    // the four payload bytes follow, least significant first.
    typedef struct packed {
        node_id_t dest;
        node_id_t src;
        word_t    payload;
    } pkt_t;

    // where a packet leaves the tile.
    typedef enum logic [1:0] {
        ROUTE_LOCAL,
        ROUTE_X,
        ROUTE_Y
    } route_t;

endpackage

// ==== src/chiplet_cfg.svh ====
`ifndef CHIPLET_CFG_SVH
`define CHIPLET_CFG_SVH

// grid size and link count per tile.
`define NUM_TILES 4
`define NUM_LINKS 2

// serial link bit period in clock cycles.
`define CLKS_PER_BIT 8

`define RX_FIFO_DEPTH 4

// byte offsets of the tile bus registers.
`define REG_TX_DATA 32'h0000_0000
`define REG_TX_CTRL 32'h0000_0004
`define REG_RX_DATA 32'h0000_0008
`define REG_STATUS  32'h0000_000C

`endif
